// File: hdl/arb_pkg.sv
`default_nettype none

package arb_pkg;

	// 68000 page address is byte address bits 23..8
	localparam int M68K_PAGE_W = 16;
	localparam int Z80_ADDR_W  = 16;
	localparam int BANK_W      = 9;
	localparam int BUS_ADDR_W  = 24;

	typedef logic [M68K_PAGE_W-1:0] m68k_page_t;

	// single 256-byte pages on the 68000 side
	localparam m68k_page_t PAGE_IO     = 16'hA100;
	localparam m68k_page_t PAGE_BUSREQ = 16'hA111;
	localparam m68k_page_t PAGE_ZRESET = 16'hA112;
	localparam m68k_page_t PAGE_FDC    = 16'hA120;
	localparam m68k_page_t PAGE_TIME   = 16'hA130;

	// upper byte of the 64 KB Z80 space
	localparam logic [7:0] ZSPACE_HI = 8'hA0;

	// VDP window lands at 0xC000xx
	localparam logic [BANK_W-1:0] VDP_BANK = 9'h180;

	// Z80 high address bytes
	localparam logic [7:0] ZBANK_WR_HI = 8'h60;
	localparam logic [7:0] ZVDP_HI     = 8'h7F;

	typedef enum logic [2:0] {
		ZR_NONE,
		ZR_RAM,
		ZR_SOUND,
		ZR_BANK_WR,
		ZR_VDP,
		ZR_BANK
	} z80_region_t;

endpackage

`default_nettype wire

// File: hdl/m68k_decode.sv
`timescale 1ns/1ns
`default_nettype none

module m68k_decode
(
	input  arb_pkg::m68k_page_t m68k_addr_i,
	input  logic                as_n_i,
	input  logic                uds_n_i,
	input  logic                rw_i,
	output logic                io_n_o,
	output logic                time_n_o,
	output logic                fdc_n_o,
	output logic                zspace_n_o,
	output logic                busreq_wr_o,
	output logic                zreset_wr_o
);
	import arb_pkg::*;

	logic hit_io;
	logic hit_time;
	logic hit_fdc;
	logic hit_zspace;
	logic hit_busreq;
	logic hit_zreset;
	logic wr_strobe;

	// page matches, the pages are disjoint so only one can hit
	assign hit_io     = (m68k_addr_i == PAGE_IO);
	assign hit_time   = (m68k_addr_i == PAGE_TIME);
	assign hit_fdc    = (m68k_addr_i == PAGE_FDC);
	assign hit_busreq = (m68k_addr_i == PAGE_BUSREQ);
	assign hit_zreset = (m68k_addr_i == PAGE_ZRESET);

	// whole 64 KB Z80 space, A00000-A0FFFF
	assign hit_zspace = (m68k_addr_i[M68K_PAGE_W-1 -: 8] == ZSPACE_HI);

	// chip selects, active low, qualified by address strobe
	assign io_n_o     = as_n_i | ~hit_io;
	assign time_n_o   = as_n_i | ~hit_time;
	assign fdc_n_o    = as_n_i | ~hit_fdc;
	assign zspace_n_o = as_n_i | ~hit_zspace;

	// upper byte write cycle, data bit 8 carries the value
	assign wr_strobe = ~as_n_i & ~uds_n_i & ~rw_i;

	assign busreq_wr_o = wr_strobe & hit_busreq;
	assign zreset_wr_o = wr_strobe & hit_zreset;

endmodule

`default_nettype wire

// File: hdl/z80_ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

module z80_ctrl_regs
(
	input  logic MCLK,
	input  logic reset_i,
	input  logic busreq_wr_i,
	input  logic zreset_wr_i,
	input  logic d8_i,
	output logic z80_busreq_o,
	output logic z80_reset_n_o
);

	// bit 0 is bus request, bit 1 is Z80 reset
	logic [1:0] wr_sel;
	logic [1:0] wr_sel_q;
	logic [1:0] wr_first;
	logic [1:0] ctrl_q;

	assign wr_sel = {zreset_wr_i, busreq_wr_i};

	// rising edge of a write select
	assign wr_first = wr_sel & ~wr_sel_q;

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			wr_sel_q <= 2'b00;
			ctrl_q   <= 2'b00;
		end
		else
		begin
			wr_sel_q <= wr_sel;
			if (wr_first[0])
				ctrl_q[0] <= d8_i;
			if (wr_first[1])
				ctrl_q[1] <= d8_i;
		end
	end

	// Z80 stays in reset until software writes a 1
	assign z80_busreq_o  = ctrl_q[0];
	assign z80_reset_n_o = ctrl_q[1];

endmodule

`default_nettype wire

// File: hdl/z80_decode.sv
`timescale 1ns/1ns
`default_nettype none

module z80_decode
(
	input  logic [arb_pkg::Z80_ADDR_W-1:0] z80_addr_i,
	input  logic                           mreq_n_i,
	input  logic                           z80_wr_n_i,
	output arb_pkg::z80_region_t           region_o,
	output logic                           zram_n_o,
	output logic                           sound_n_o
);
	import arb_pkg::*;

	logic [7:0] addr_hi;

	assign addr_hi = z80_addr_i[Z80_ADDR_W-1 -: 8];

	always_comb
	begin
		region_o = ZR_NONE;
		if (!mreq_n_i)
		begin
			// 0000-3FFF
			if (addr_hi[7:6] == 2'b00)
				region_o = ZR_RAM;
			// 4000-5FFF
			else if (addr_hi[7:5] == 3'b010)
				region_o = ZR_SOUND;
			// bank register only takes writes
			else if (addr_hi == ZBANK_WR_HI && !z80_wr_n_i)
				region_o = ZR_BANK_WR;
			else if (addr_hi == ZVDP_HI)
				region_o = ZR_VDP;
			// upper half goes through the bank window
			else if (addr_hi[7])
				region_o = ZR_BANK;
		end
	end

	assign zram_n_o  = (region_o != ZR_RAM);
	assign sound_n_o = (region_o != ZR_SOUND);

endmodule

`default_nettype wire

// File: hdl/z80_bank_map.sv
`timescale 1ns/1ns
`default_nettype none

module z80_bank_map
(
	input  logic                           MCLK,
	input  logic                           reset_i,
	input  arb_pkg::z80_region_t           region_i,
	input  logic [arb_pkg::Z80_ADDR_W-1:0] z80_addr_i,
	input  logic                           z80_d0_i,
	output logic [arb_pkg::BUS_ADDR_W-1:0] bus_addr_o,
	output logic                           addr_valid_o
);
	import arb_pkg::*;

	logic [BANK_W-1:0] bank_q;
	logic              bank_wr;
	logic              bank_wr_q;
	logic              bank_shift;

	assign bank_wr = (region_i == ZR_BANK_WR);

	// one shift per access, however long the write is held
	assign bank_shift = bank_wr & ~bank_wr_q;

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			bank_wr_q <= 1'b0;
			bank_q    <= '0;
		end
		else
		begin
			bank_wr_q <= bank_wr;
			// new bit enters at the top, serial write from d0
			if (bank_shift)
				bank_q <= {z80_d0_i, bank_q[BANK_W-1:1]};
		end
	end

	always_comb
	begin
		bus_addr_o   = '0;
		addr_valid_o = 1'b0;
		case (region_i)
			ZR_BANK:
			begin
				// 32 KB window, bank selects A23..A15
				bus_addr_o   = {bank_q, z80_addr_i[Z80_ADDR_W-2:0]};
				addr_valid_o = 1'b1;
			end
			ZR_VDP:
			begin
				bus_addr_o   = {VDP_BANK, 7'b0, z80_addr_i[7:0]};
				addr_valid_o = 1'b1;
			end
			default:
			begin
				bus_addr_o   = '0;
				addr_valid_o = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/ym6045_top.sv
`timescale 1ns/1ns
`default_nettype none

module ym6045_top
(
	input  logic                           MCLK,
	input  logic                           reset_i,
	input  arb_pkg::m68k_page_t            m68k_addr_i,
	input  logic                           as_n_i,
	input  logic                           uds_n_i,
	input  logic                           rw_i,
	input  logic                           d8_i,
	input  logic [arb_pkg::Z80_ADDR_W-1:0] z80_addr_i,
	input  logic                           mreq_n_i,
	input  logic                           z80_wr_n_i,
	input  logic                           z80_d0_i,
	output logic                           io_n_o,
	output logic                           time_n_o,
	output logic                           fdc_n_o,
	output logic                           zspace_n_o,
	output logic                           zram_n_o,
	output logic                           sound_n_o,
	output logic [arb_pkg::BUS_ADDR_W-1:0] z80_bus_addr_o,
	output logic                           z80_addr_valid_o,
	output logic                           z80_busreq_o,
	output logic                           z80_reset_n_o
);
	import arb_pkg::*;

	logic        busreq_wr;
	logic        zreset_wr;
	z80_region_t region;

	m68k_decode u_m68k_decode (
		.m68k_addr_i (m68k_addr_i),
		.as_n_i      (as_n_i),
		.uds_n_i     (uds_n_i),
		.rw_i        (rw_i),
		.io_n_o      (io_n_o),
		.time_n_o    (time_n_o),
		.fdc_n_o     (fdc_n_o),
		.zspace_n_o  (zspace_n_o),
		.busreq_wr_o (busreq_wr),
		.zreset_wr_o (zreset_wr)
	);

	z80_ctrl_regs u_z80_ctrl_regs (
		.MCLK          (MCLK),
		.reset_i       (reset_i),
		.busreq_wr_i   (busreq_wr),
		.zreset_wr_i   (zreset_wr),
		.d8_i          (d8_i),
		.z80_busreq_o  (z80_busreq_o),
		.z80_reset_n_o (z80_reset_n_o)
	);

	z80_decode u_z80_decode (
		.z80_addr_i (z80_addr_i),
		.mreq_n_i   (mreq_n_i),
		.z80_wr_n_i (z80_wr_n_i),
		.region_o   (region),
		.zram_n_o   (zram_n_o),
		.sound_n_o  (sound_n_o)
	);

	z80_bank_map u_z80_bank_map (
		.MCLK         (MCLK),
		.reset_i      (reset_i),
		.region_i     (region),
		.z80_addr_i   (z80_addr_i),
		.z80_d0_i     (z80_d0_i),
		.bus_addr_o   (z80_bus_addr_o),
		.addr_valid_o (z80_addr_valid_o)
	);

endmodule

`default_nettype wire

// File: dv/ym6045_props.sv
`timescale 1ns/1ns
`default_nettype none

module ym6045_props
(
	input logic                       MCLK,
	input logic                       reset_i,
	input logic [arb_pkg::BANK_W-1:0] bank_i,
	input arb_pkg::z80_region_t       region_i,
	input logic                       busreq_i,
	input logic                       reset_n_i,
	input logic                       io_n_i,
	input logic                       time_n_i,
	input logic                       fdc_n_i,
	input logic                       zspace_n_i
);
	import arb_pkg::*;

	// both control registers come out of reset cleared
	ctrl_after_reset: assert property (@(posedge MCLK)
		$past(reset_i) |-> (!busreq_i && !reset_n_i))
		else $error("Z80 control registers not cleared after reset");

	// bank only moves on the first cycle of a bank write
	bank_needs_write: assert property (@(posedge MCLK) disable iff (reset_i)
		(bank_i != $past(bank_i)) |->
			($past(region_i) == ZR_BANK_WR && $past(region_i, 2) != ZR_BANK_WR))
		else $error("bank register changed without a bank write");

	one_chip_select: assert property (@(posedge MCLK)
		$onehot0({~io_n_i, ~time_n_i, ~fdc_n_i, ~zspace_n_i}))
		else $error("more than one 68000 chip select active");

endmodule

bind ym6045_top ym6045_props u_props (
	.MCLK       (MCLK),
	.reset_i    (reset_i),
	.bank_i     (u_z80_bank_map.bank_q),
	.region_i   (region),
	.busreq_i   (z80_busreq_o),
	.reset_n_i  (z80_reset_n_o),
	.io_n_i     (io_n_o),
	.time_n_i   (time_n_o),
	.fdc_n_i    (fdc_n_o),
	.zspace_n_i (zspace_n_o)
);

`default_nettype wire

// File: dv/ym6045_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ym6045_tb;

	localparam int    MAX_VEC      = 100;
	localparam int    MAX_HOLD     = 16;
	localparam int    RESET_CYCLES = 4;
	localparam int    LIMIT_CYCLES = 2000;
	localparam string VEC_FILE     = "dv/stim_input.txt";

	logic        MCLK = 1'b0;
	logic        reset_i;
	logic [15:0] m68k_addr_i;
	logic        as_n_i;
	logic        uds_n_i;
	logic        rw_i;
	logic        d8_i;
	logic [15:0] z80_addr_i;
	logic        mreq_n_i;
	logic        z80_wr_n_i;
	logic        z80_d0_i;
	logic        io_n_o;
	logic        time_n_o;
	logic        fdc_n_o;
	logic        zspace_n_o;
	logic        zram_n_o;
	logic        sound_n_o;
	logic [23:0] z80_bus_addr_o;
	logic        z80_addr_valid_o;
	logic        z80_busreq_o;
	logic        z80_reset_n_o;

	logic [31:0] vec_mem [0:1023];
	logic [9:0]  vec_ptr;
	int          checks;
	int          mismatches;
	int          other_errors;

	ym6045_top uut (.*);

	always #20 MCLK = ~MCLK;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			mismatches++;
			$display("[ERROR] %s expected=%0h actual=%0h", name, expected, actual);
		end
	endtask

	function automatic logic [31:0] next_word();
		logic [31:0] w;
		w = vec_mem[vec_ptr];
		vec_ptr = vec_ptr + 10'd1;
		return w;
	endfunction

	function automatic logic [31:0] selects_now();
		return {26'd0, io_n_o, time_n_o, fdc_n_o, zspace_n_o, zram_n_o, sound_n_o};
	endfunction

	task automatic drive_idle();
		m68k_addr_i <= 16'h0000;
		as_n_i      <= 1'b1;
		uds_n_i     <= 1'b1;
		rw_i        <= 1'b1;
		d8_i        <= 1'b0;
		z80_addr_i  <= 16'h0000;
		mreq_n_i    <= 1'b1;
		z80_wr_n_i  <= 1'b1;
		z80_d0_i    <= 1'b0;
	endtask

	// one vector: hold the access, then one idle cycle for the registers
	task automatic run_access(input int idx);
		logic [31:0] side;
		logic [31:0] addr;
		logic [31:0] strobes;
		logic [31:0] data;
		logic [31:0] exp_sel;
		logic [31:0] exp_addr;
		logic [31:0] exp_valid;
		logic [31:0] exp_busreq;
		logic [31:0] exp_rst_n;
		int          hold;
		side       = next_word();
		addr       = next_word();
		strobes    = next_word();
		data       = next_word();
		hold       = next_word();
		exp_sel    = next_word();
		exp_addr   = next_word();
		exp_valid  = next_word();
		exp_busreq = next_word();
		exp_rst_n  = next_word();
		if (hold < 1 || hold > MAX_HOLD)
		begin
			$display("vector %0d has hold length %0d, outside 1 to %0d", idx, hold, MAX_HOLD);
			other_errors++;
			hold = 1;
		end
		@(posedge MCLK);
		if (side == 32'd0)
		begin
			m68k_addr_i <= addr[15:0];
			as_n_i      <= strobes[2];
			uds_n_i     <= strobes[1];
			rw_i        <= strobes[0];
			d8_i        <= data[0];
		end
		else
		begin
			z80_addr_i <= addr[15:0];
			mreq_n_i   <= strobes[1];
			z80_wr_n_i <= strobes[0];
			z80_d0_i   <= data[0];
		end
		for (int c = 0; c < hold; c++)
		begin
			@(negedge MCLK);
			check_value($sformatf("vector %0d selects", idx), exp_sel, selects_now());
			check_value($sformatf("vector %0d address", idx), exp_addr, {8'd0, z80_bus_addr_o});
			check_value($sformatf("vector %0d valid", idx), exp_valid, {31'd0, z80_addr_valid_o});
			if (c + 1 < hold)
				@(posedge MCLK);
		end
		@(posedge MCLK);
		drive_idle();
		@(negedge MCLK);
		check_value($sformatf("vector %0d busreq", idx), exp_busreq, {31'd0, z80_busreq_o});
		check_value($sformatf("vector %0d reset_n", idx), exp_rst_n, {31'd0, z80_reset_n_o});
	endtask

	initial
	begin
		int   fd;
		int   nvec;
		logic found_end;
		checks       = 0;
		mismatches   = 0;
		other_errors = 0;
		vec_ptr      = 10'd0;
		nvec         = 0;
		found_end    = 1'b0;
		reset_i      = 1'b1;
		m68k_addr_i  = 16'h0000;
		as_n_i       = 1'b1;
		uds_n_i      = 1'b1;
		rw_i         = 1'b1;
		d8_i         = 1'b0;
		z80_addr_i   = 16'h0000;
		mreq_n_i     = 1'b1;
		z80_wr_n_i   = 1'b1;
		z80_d0_i     = 1'b0;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0)
		begin
			$display("cannot open the vector file %s", VEC_FILE);
			other_errors++;
		end
		else
		begin
			$fclose(fd);
			$readmemh(VEC_FILE, vec_mem);
		end
		for (int n = 0; n < RESET_CYCLES; n++)
			@(posedge MCLK);
		reset_i <= 1'b0;
		@(negedge MCLK);
		check_value("reset busreq", 32'd0, {31'd0, z80_busreq_o});
		check_value("reset reset_n", 32'd0, {31'd0, z80_reset_n_o});
		check_value("reset selects", 32'h3f, selects_now());
		check_value("reset valid", 32'd0, {31'd0, z80_addr_valid_o});
		while (fd != 0 && !found_end && nvec < MAX_VEC)
		begin
			if (vec_mem[vec_ptr] == 32'd2)
				found_end = 1'b1;
			else
			begin
				run_access(nvec);
				nvec++;
			end
		end
		if (fd != 0 && !found_end)
		begin
			$display("no end marker found within %0d vectors", MAX_VEC);
			other_errors++;
		end
		$display("checks: %0d, mismatches: %0d, other errors: %0d",
			checks, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// watchdog in case a vector never completes
	initial
	begin
		for (int i = 0; i < LIMIT_CYCLES; i++)
			@(posedge MCLK);
		$display("timeout: vectors not finished after %0d clock cycles", LIMIT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
hdl/arb_pkg.sv
hdl/m68k_decode.sv
hdl/z80_ctrl_regs.sv
hdl/z80_decode.sv
hdl/z80_bank_map.sv
hdl/ym6045_top.sv
dv/ym6045_props.sv
dv/ym6045_tb.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns --top-module ym6045_tb \
	-f src.f --Mdir obj_dir -o ym6045_sim &&
./obj_dir/ym6045_sim | tee /dev/stderr | grep -x "SIMULATION PASSED" > /dev/null &&
echo "run.sh: testbench reported success" ||
{ echo "run.sh: build or simulation failed"; exit 1; }

// File: dv/stim_input.txt
// side(0=68000 1=Z80 2=end) addr strobes(68k:as_n,uds_n,rw z80:mreq_n,wr_n) data hold
// exp_sel(io_n,time_n,fdc_n,zspace_n,zram_n,sound_n) exp_addr exp_valid exp_busreq exp_reset_n
0 A100 1 0 1 1F 000000 0 0 0
0 A130 1 0 1 2F 000000 0 0 0
0 A120 1 0 1 37 000000 0 0 0
0 A012 1 0 1 3B 000000 0 0 0
0 A100 7 0 1 3F 000000 0 0 0
0 A130 7 0 1 3F 000000 0 0 0
0 A012 7 0 1 3F 000000 0 0 0
1 1234 1 0 1 3D 000000 0 0 0
1 4567 1 0 1 3E 000000 0 0 0
1 2000 1 0 1 3D 000000 0 0 0
1 1234 3 0 1 3F 000000 0 0 0
1 4567 3 0 1 3F 000000 0 0 0
1 7F11 1 0 1 3F C00011 1 0 0
// nine bank writes, bits 1 0 1 1 0 0 1 0 1, the fourth held for 5 cycles
1 6000 0 1 1 3F 000000 0 0 0
1 6000 0 0 1 3F 000000 0 0 0
1 6000 0 1 1 3F 000000 0 0 0
1 6000 0 1 5 3F 000000 0 0 0
1 6000 0 0 1 3F 000000 0 0 0
1 6000 0 0 1 3F 000000 0 0 0
1 6000 0 1 1 3F 000000 0 0 0
1 6000 0 0 1 3F 000000 0 0 0
1 6000 0 1 1 3F 000000 0 0 0
1 6000 1 1 1 3F 000000 0 0 0
1 9ABC 1 0 1 3F A69ABC 1 0 0
0 A111 0 1 1 3F 000000 0 1 0
0 A112 0 1 1 3F 000000 0 1 1
0 A111 1 0 1 3F 000000 0 1 1
0 A112 1 0 1 3F 000000 0 1 1
0 A111 0 0 1 3F 000000 0 0 1
0 A112 0 0 3 3F 000000 0 0 0
2 0 0 0 0 0 0 0 0 0
